// File: hdl/core_params.svh
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// major opcodes, instr[6:0]
`define OPC_OP      7'b0110011  // register-register
`define OPC_OPIMM   7'b0010011  // register-immediate
`define OPC_LOAD    7'b0000011
`define OPC_STORE   7'b0100011

// funct7, instr[31:25]
`define F7_ADD      7'b0000000
`define F7_SUB      7'b0100000
`define F7_MULDIV   7'b0000001  // M extension group

// funct3, instr[14:12]
`define F3_ADD      3'b000      // ADD, SUB, ADDI
`define F3_WORD     3'b010      // LW and SW width
`define F3_DIVU     3'b101

// alu operation codes
`define ALU_ADD     3'd0
`define ALU_SUB     3'd1
`define ALU_PASS    3'd2        // result is the divider quotient

// forwarding selects, MEM wins over WB
`define FWD_NONE    2'd0        // operand from register file
`define FWD_WB      2'd1
`define FWD_MEM     2'd2

`define DIV_CYCLES  32          // one quotient bit per step

`endif

// File: hdl/core_pkg.sv
`default_nettype none

package core_pkg;

    // data path and address width
    typedef logic [31:0] word_t;

    // architectural register number, x0..x31
    typedef logic [4:0] reg_idx_t;

    // operand source select in EX
    typedef logic [1:0] fwd_sel_t;

    // alu function code from the decoder
    typedef logic [2:0] alu_op_t;

    // iterative divider sequencing
    typedef enum logic [1:0] {
        DIV_IDLE,  // waiting for start
        DIV_RUN,   // shift-subtract steps
        DIV_DONE   // quotient valid, one cycle
    } div_state_t;

endpackage

`default_nettype wire

// File: hdl/hazard_unit.sv
`default_nettype none
`timescale 1ns/1ps
`include "core_params.svh"

module hazard_unit import core_pkg::*; (
    input  reg_idx_t rd_e,
    input  reg_idx_t rd_m,
    input  reg_idx_t rd_w,
    input  reg_idx_t rs1_d,
    input  reg_idx_t rs2_d,
    input  reg_idx_t rs1_e,
    input  reg_idx_t rs2_e,
    input  logic     rs1_used_d,   // decode reads rs1
    input  logic     rs2_used_d,   // decode reads rs2
    input  logic     rs1_used_e,   // EX reads rs1
    input  logic     rs2_used_e,   // EX reads rs2
    input  logic     reg_write_m,  // valid writer in MEM
    input  logic     reg_write_w,  // valid writer in WB
    input  logic     load_e,       // valid load in EX
    input  logic     div_busy_e,   // divider holds EX
    input  logic     mem_ready_m,  // data port not waiting

    output logic     stall,        // load-use bubble
    output fwd_sel_t fwd_rs1,
    output fwd_sel_t fwd_rs2,
    output logic     div_stall,
    output logic     cache_stall
);

logic hit_m_rs1;
logic hit_w_rs1;
logic hit_m_rs2;
logic hit_w_rs2;
logic load_use;

// a producer matches only if it writes and is not x0
assign hit_m_rs1 = reg_write_m && (rd_m != '0) && (rd_m == rs1_e);
assign hit_w_rs1 = reg_write_w && (rd_w != '0) && (rd_w == rs1_e);
assign hit_m_rs2 = reg_write_m && (rd_m != '0) && (rd_m == rs2_e);
assign hit_w_rs2 = reg_write_w && (rd_w != '0) && (rd_w == rs2_e);

always_comb begin
    fwd_rs1 = `FWD_NONE;
    if (rs1_used_e) begin
        if (hit_m_rs1) begin
            fwd_rs1 = `FWD_MEM;     // youngest result first
        end else if (hit_w_rs1) begin
            fwd_rs1 = `FWD_WB;
        end
    end
end

always_comb begin
    fwd_rs2 = `FWD_NONE;
    if (rs2_used_e) begin
        if (hit_m_rs2) begin
            fwd_rs2 = `FWD_MEM;
        end else if (hit_w_rs2) begin
            fwd_rs2 = `FWD_WB;
        end
    end
end

// load data only exists after MEM, so a consumer right behind must wait a cycle
assign load_use = load_e && (rd_e != '0) &&
                  ((rs1_used_d && (rd_e == rs1_d)) || (rs2_used_d && (rd_e == rs2_d)));

assign stall       = load_use;
assign div_stall   = div_busy_e;     // EX occupied until quotient
assign cache_stall = !mem_ready_m;   // data port back-pressure

endmodule

`default_nettype wire

// File: hdl/reg_file.sv
`default_nettype none
`timescale 1ns/1ps

module reg_file import core_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     we,      // WB commit
    input  reg_idx_t waddr,
    input  word_t    wdata,
    input  reg_idx_t raddr1,
    input  reg_idx_t raddr2,
    output word_t    rdata1,
    output word_t    rdata2
);

word_t regs [1:31];   // x0 has no storage

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        for (int i = 1; i < 32; i++) begin
            regs[i] <= '0;
        end
    end else if (we && (waddr != '0)) begin
        regs[waddr] <= wdata;
    end
end

// write-through so decode sees the value WB commits this cycle
assign rdata1 = (raddr1 == '0)                ? '0    :
                (we && (waddr == raddr1))     ? wdata :
                                                regs[raddr1];

assign rdata2 = (raddr2 == '0)                ? '0    :
                (we && (waddr == raddr2))     ? wdata :
                                                regs[raddr2];

endmodule

`default_nettype wire

// File: hdl/instr_decoder.sv
`default_nettype none
`timescale 1ns/1ps
`include "core_params.svh"

module instr_decoder import core_pkg::*; (
    input  word_t    instr,
    output reg_idx_t rs1,
    output reg_idx_t rs2,
    output reg_idx_t rd,
    output logic     rs1_used,
    output logic     rs2_used,
    output logic     reg_write,
    output logic     is_load,
    output logic     is_store,
    output logic     is_div,
    output logic     use_imm,   // alu operand b from imm
    output logic     illegal,   // outside the subset, becomes a bubble
    output word_t    imm,
    output alu_op_t  alu_op
);

logic [6:0] opcode;
logic [2:0] funct3;
logic [6:0] funct7;
word_t      imm_i;
word_t      imm_s;

assign opcode = instr[6:0];
assign funct3 = instr[14:12];
assign funct7 = instr[31:25];
assign rd     = instr[11:7];
assign rs1    = instr[19:15];
assign rs2    = instr[24:20];

assign imm_i = {{20{instr[31]}}, instr[31:20]};
assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
assign imm   = (opcode == `OPC_STORE) ? imm_s : imm_i;

always_comb begin
    rs1_used  = 1'b0;      // everything off unless a legal match
    rs2_used  = 1'b0;
    reg_write = 1'b0;
    is_load   = 1'b0;
    is_store  = 1'b0;
    is_div    = 1'b0;
    use_imm   = 1'b0;
    illegal   = 1'b1;
    alu_op    = `ALU_ADD;
    case (opcode)
        `OPC_OP: begin
            if ((funct3 == `F3_ADD) && ((funct7 == `F7_ADD) || (funct7 == `F7_SUB))) begin
                illegal   = 1'b0;
                rs1_used  = 1'b1;
                rs2_used  = 1'b1;
                reg_write = 1'b1;
                alu_op    = (funct7 == `F7_SUB) ? `ALU_SUB : `ALU_ADD;
            end else if ((funct3 == `F3_DIVU) && (funct7 == `F7_MULDIV)) begin
                illegal   = 1'b0;
                rs1_used  = 1'b1;
                rs2_used  = 1'b1;
                reg_write = 1'b1;
                is_div    = 1'b1;
                alu_op    = `ALU_PASS;   // quotient from the divider
            end
        end
        `OPC_OPIMM: begin
            if (funct3 == `F3_ADD) begin   // ADDI only
                illegal   = 1'b0;
                rs1_used  = 1'b1;
                reg_write = 1'b1;
                use_imm   = 1'b1;
            end
        end
        `OPC_LOAD: begin
            if (funct3 == `F3_WORD) begin
                illegal   = 1'b0;
                rs1_used  = 1'b1;          // base address
                reg_write = 1'b1;
                is_load   = 1'b1;
                use_imm   = 1'b1;
            end
        end
        `OPC_STORE: begin
            if (funct3 == `F3_WORD) begin
                illegal   = 1'b0;
                rs1_used  = 1'b1;
                rs2_used  = 1'b1;          // store data
                is_store  = 1'b1;
                use_imm   = 1'b1;
            end
        end
        default: ;
    endcase
end

endmodule

`default_nettype wire

// File: hdl/iter_divider.sv
`default_nettype none
`timescale 1ns/1ps
`include "core_params.svh"

module iter_divider import core_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  start,     // sampled only when idle
    input  word_t dividend,
    input  word_t divisor,
    output logic  busy,
    output logic  done,      // one-cycle strobe
    output word_t quotient
);

div_state_t  state;
logic [5:0]  step;        // iteration count
word_t       quo;         // dividend shifts out, quotient bits shift in
word_t       rem;         // partial remainder, always below the divisor
word_t       dvsr;
logic        dvsr_zero;
logic [32:0] rem_shift;
logic [32:0] trial;

assign rem_shift = {rem, quo[31]};            // bring down next dividend bit
assign trial     = rem_shift - {1'b0, dvsr};  // msb set means it does not fit

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        state <= DIV_IDLE;
        step  <= '0;
    end else begin
        case (state)
            DIV_IDLE: begin
                if (start) begin
                    state <= DIV_RUN;
                    step  <= '0;
                end
            end
            DIV_RUN: begin
                step <= step + 6'd1;
                if (step == 6'(`DIV_CYCLES - 1)) begin
                    state <= DIV_DONE;
                end
            end
            default: state <= DIV_IDLE;   // done lasts a single cycle
        endcase
    end
end

always_ff @(posedge clk) begin
    if ((state == DIV_IDLE) && start) begin
        quo       <= dividend;
        rem       <= '0;
        dvsr      <= divisor;
        dvsr_zero <= (divisor == '0);
    end else if (state == DIV_RUN) begin
        if (!trial[32]) begin
            rem <= trial[31:0];               // subtract and keep
            quo <= {quo[30:0], 1'b1};
        end else begin
            rem <= rem_shift[31:0];           // restore
            quo <= {quo[30:0], 1'b0};
        end
    end
end

assign busy     = (state == DIV_RUN);
assign done     = (state == DIV_DONE);
assign quotient = dvsr_zero ? '1 : quo;       // RISC-V x/0 gives all ones

endmodule

`default_nettype wire

// File: hdl/pipe_core.sv
`default_nettype none
`timescale 1ns/1ps
`include "core_params.svh"

module pipe_core import core_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    output word_t    imem_addr,
    input  word_t    imem_data,     // combinational instruction fetch
    output logic     dmem_req,
    output logic     dmem_we,
    output word_t    dmem_addr,
    output word_t    dmem_wdata,
    input  logic     dmem_ready,
    input  word_t    dmem_rdata,    // valid with req and ready
    output logic     retire_valid,
    output reg_idx_t retire_rd,
    output word_t    retire_value
);

// fetch and IF/ID
word_t    pc;
logic     valid_d;
word_t    instr_d;

// decode outputs
reg_idx_t rs1_d, rs2_d, rd_d;
logic     rs1_used_d, rs2_used_d, reg_write_d, illegal_d;
logic     is_load_d, is_store_d, is_div_d, use_imm_d;
word_t    imm_d, rdata1_d, rdata2_d;
alu_op_t  alu_op_d;

// ID/EX
logic     valid_e;
reg_idx_t rs1_e, rs2_e, rd_e;
logic     rs1_used_e, rs2_used_e, reg_write_e;
logic     is_load_e, is_store_e, is_div_e, use_imm_e;
word_t    imm_e, rdata1_e, rdata2_e;
alu_op_t  alu_op_e;
word_t    op_a_e;       // forwarded rs1
word_t    op_b_e;       // forwarded rs2, also store data
word_t    alu_b_e;
word_t    alu_res_e;

// divider handshake
logic     div_start, div_busy, div_done;
logic     div_hold;     // quotient delivered, DIVU still frozen in EX
word_t    div_quot;

// EX/MEM and MEM/WB
logic     valid_m, reg_write_m, is_load_m, is_store_m;
reg_idx_t rd_m;
word_t    alu_res_m, wdata_m, result_m;
logic     valid_w, reg_write_w, wb_commit;
reg_idx_t rd_w;
word_t    result_w;

// hazard unit
logic     stall, div_stall, cache_stall, mem_ready_m;
fwd_sel_t fwd_rs1, fwd_rs2;
logic     hold_front;   // fetch and decode frozen
logic     hold_ex;      // EX frozen

function automatic word_t fwd_mux(input fwd_sel_t sel, input word_t rf_val,
                                  input word_t mem_val, input word_t wb_val);
    case (sel)
        `FWD_MEM: fwd_mux = mem_val;
        `FWD_WB:  fwd_mux = wb_val;
        default:  fwd_mux = rf_val;
    endcase
endfunction

assign hold_front = cache_stall || div_stall || stall;
assign hold_ex    = cache_stall || div_stall;
assign imem_addr  = pc;

instr_decoder i_decoder (
    .instr(instr_d), .rs1(rs1_d), .rs2(rs2_d), .rd(rd_d),
    .rs1_used(rs1_used_d), .rs2_used(rs2_used_d), .reg_write(reg_write_d),
    .is_load(is_load_d), .is_store(is_store_d), .is_div(is_div_d),
    .use_imm(use_imm_d), .illegal(illegal_d), .imm(imm_d), .alu_op(alu_op_d)
);

reg_file i_reg_file (
    .clk(clk), .rst_n(rst_n), .we(wb_commit), .waddr(rd_w), .wdata(result_w),
    .raddr1(rs1_d), .raddr2(rs2_d), .rdata1(rdata1_d), .rdata2(rdata2_d)
);

hazard_unit i_hazard (
    .rd_e(rd_e), .rd_m(rd_m), .rd_w(rd_w),
    .rs1_d(rs1_d), .rs2_d(rs2_d), .rs1_e(rs1_e), .rs2_e(rs2_e),
    .rs1_used_d(valid_d && rs1_used_d), .rs2_used_d(valid_d && rs2_used_d),
    .rs1_used_e(valid_e && rs1_used_e), .rs2_used_e(valid_e && rs2_used_e),
    .reg_write_m(valid_m && reg_write_m), .reg_write_w(valid_w && reg_write_w),
    .load_e(valid_e && is_load_e), .div_busy_e(div_start || div_busy),
    .mem_ready_m(mem_ready_m),
    .stall(stall), .fwd_rs1(fwd_rs1), .fwd_rs2(fwd_rs2),
    .div_stall(div_stall), .cache_stall(cache_stall)
);

// EX operand select and alu
assign op_a_e  = fwd_mux(fwd_rs1, rdata1_e, alu_res_m, result_w);
assign op_b_e  = fwd_mux(fwd_rs2, rdata2_e, alu_res_m, result_w);
assign alu_b_e = use_imm_e ? imm_e : op_b_e;

always_comb begin
    case (alu_op_e)
        `ALU_SUB:  alu_res_e = op_a_e - alu_b_e;
        `ALU_PASS: alu_res_e = div_quot;    // valid in the done cycle
        default:   alu_res_e = op_a_e + alu_b_e;   // also load/store address
    endcase
end

// start once per DIVU, operands latched by the divider
assign div_start = valid_e && is_div_e && !div_busy && !div_done && !div_hold;

iter_divider i_divider (
    .clk(clk), .rst_n(rst_n), .start(div_start), .dividend(op_a_e), .divisor(op_b_e),
    .busy(div_busy), .done(div_done), .quotient(div_quot)
);

// MEM stage, request held while the pipe is frozen
assign dmem_req    = valid_m && (is_load_m || is_store_m);
assign dmem_we     = valid_m && is_store_m;
assign dmem_addr   = alu_res_m;
assign dmem_wdata  = wdata_m;
assign mem_ready_m = !dmem_req || dmem_ready;
assign result_m    = is_load_m ? dmem_rdata : alu_res_m;

// WB commits once, on the cycle it is allowed to move on
assign wb_commit    = valid_w && reg_write_w && !cache_stall;
assign retire_valid = wb_commit && (rd_w != '0);
assign retire_rd    = rd_w;
assign retire_value = result_w;

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        pc       <= '0;
        valid_d  <= 1'b0;
        valid_e  <= 1'b0;
        valid_m  <= 1'b0;
        valid_w  <= 1'b0;
        div_hold <= 1'b0;
    end else begin
        if (!hold_front) begin
            pc      <= pc + 32'd4;
            valid_d <= 1'b1;
        end
        if (!hold_ex) begin
            valid_e <= valid_d && !illegal_d && !stall;   // load-use bubble
        end
        if (!cache_stall) begin
            valid_m <= valid_e && !div_stall;             // divide bubble
            valid_w <= valid_m;
        end
        div_hold <= (div_hold || div_done) && cache_stall;
    end
end

always_ff @(posedge clk) begin
    if (!hold_front) begin
        instr_d <= imem_data;
    end
    if (!hold_ex) begin
        rs1_e       <= rs1_d;
        rs2_e       <= rs2_d;
        rd_e        <= rd_d;
        rs1_used_e  <= rs1_used_d;
        rs2_used_e  <= rs2_used_d;
        reg_write_e <= reg_write_d;
        is_load_e   <= is_load_d;
        is_store_e  <= is_store_d;
        is_div_e    <= is_div_d;
        use_imm_e   <= use_imm_d;
        imm_e       <= imm_d;
        alu_op_e    <= alu_op_d;
        rdata1_e    <= rdata1_d;
        rdata2_e    <= rdata2_d;
    end
    if (!cache_stall) begin
        rd_m        <= rd_e;
        reg_write_m <= reg_write_e;
        is_load_m   <= is_load_e;
        is_store_m  <= is_store_e;
        alu_res_m   <= alu_res_e;
        wdata_m     <= op_b_e;
        rd_w        <= rd_m;
        reg_write_w <= reg_write_m;
        result_w    <= result_m;
    end
end

endmodule

`default_nettype wire

// File: test/pipe_core_assert.sv
`default_nettype none
`timescale 1ns/1ps
`include "core_params.svh"

module pipe_core_assert import core_pkg::*; (
    input logic     clk,
    input logic     rst_n,
    input fwd_sel_t fwd_rs1,       // hazard unit selects
    input fwd_sel_t fwd_rs2,
    input logic     retire_valid,
    input reg_idx_t retire_rd,
    input logic     dmem_req,
    input logic     dmem_ready,
    input logic     dmem_we,
    input word_t    dmem_addr,
    input word_t    dmem_wdata
);

// only NONE, WB and MEM are defined
fwd_rs1_code: assert property (@(posedge clk) disable iff (!rst_n)
    fwd_rs1 inside {`FWD_NONE, `FWD_WB, `FWD_MEM})
    else $error("fwd_rs1 carries an undefined select code");

fwd_rs2_code: assert property (@(posedge clk) disable iff (!rst_n)
    fwd_rs2 inside {`FWD_NONE, `FWD_WB, `FWD_MEM})
    else $error("fwd_rs2 carries an undefined select code");

// x0 writes are silent
retire_not_x0: assert property (@(posedge clk) disable iff (!rst_n)
    retire_valid |-> (retire_rd != '0))
    else $error("retire strobe names x0");

// waiting request keeps its address, data and direction
req_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (dmem_req && !dmem_ready) |=>
        (dmem_req && $stable(dmem_addr) && $stable(dmem_wdata) && $stable(dmem_we)))
    else $error("data request changed while waiting for ready");

endmodule

// fwd selects are the hazard unit outputs seen in the core
bind pipe_core pipe_core_assert i_assert (
    .clk(clk), .rst_n(rst_n), .fwd_rs1(fwd_rs1), .fwd_rs2(fwd_rs2),
    .retire_valid(retire_valid), .retire_rd(retire_rd),
    .dmem_req(dmem_req), .dmem_ready(dmem_ready), .dmem_we(dmem_we),
    .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata)
);

`default_nettype wire

// File: test/pipe_core_tb.sv
`default_nettype none
`timescale 1ns/1ps
`include "core_params.svh"

module pipe_core_tb import core_pkg::*; ();

localparam int    MAX_INSTR = 64;
localparam word_t NOP       = 32'h0000_0013;   // addi x0, x0, 0

typedef enum logic [2:0] {K_ADD, K_SUB, K_ADDI, K_LW, K_SW, K_DIVU} kind_t;

typedef struct packed {
    kind_t       kind;
    reg_idx_t    rd;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    logic [11:0] imm;
    logic        retires;   // writes a nonzero register
    word_t       value;     // expected retire value
} entry_t;

logic        clk;
logic        rst_n;
word_t       imem_addr;
word_t       imem_data;
logic        dmem_req;
logic        dmem_we;
logic        dmem_ready;
word_t       dmem_addr;
word_t       dmem_wdata;
word_t       dmem_rdata;
logic        retire_valid;
reg_idx_t    retire_rd;
word_t       retire_value;

entry_t      prog [0:MAX_INSTR-1];
word_t       rom  [0:MAX_INSTR-1];
word_t       dmem [0:63];         // 256 byte data window
int          n_instr;
int          n_retire;            // retires the table expects
int          n_seen;
int          next_ret;            // table index of the next retire
int          cycles;
int          limit;
logic [31:0] lfsr;
logic        pending;             // request seen, delay drawn
logic [1:0]  wait_left;           // not-ready cycles still to go

pipe_core i_dut (
    .clk(clk), .rst_n(rst_n), .imem_addr(imem_addr), .imem_data(imem_data),
    .dmem_req(dmem_req), .dmem_we(dmem_we), .dmem_addr(dmem_addr),
    .dmem_wdata(dmem_wdata), .dmem_ready(dmem_ready), .dmem_rdata(dmem_rdata),
    .retire_valid(retire_valid), .retire_rd(retire_rd), .retire_value(retire_value)
);

always #5 clk = ~clk;

// instruction port answers in the same cycle, NOPs past the table
assign imem_data = (imem_addr[31:8] == '0) ? rom[imem_addr[7:2]] : NOP;

function automatic word_t r_type_word(input logic [6:0] f7, input reg_idx_t rs2,
                                      input reg_idx_t rs1, input logic [2:0] f3,
                                      input reg_idx_t rd);
    r_type_word = {f7, rs2, rs1, f3, rd, `OPC_OP};
endfunction

function automatic word_t i_type_word(input logic [11:0] imm, input reg_idx_t rs1,
                                      input logic [2:0] f3, input reg_idx_t rd,
                                      input logic [6:0] opc);
    i_type_word = {imm, rs1, f3, rd, opc};
endfunction

function automatic word_t s_type_word(input logic [11:0] imm, input reg_idx_t rs2,
                                      input reg_idx_t rs1);
    s_type_word = {imm[11:5], rs2, rs1, `F3_WORD, imm[4:0], `OPC_STORE};
endfunction

function automatic word_t encode(input entry_t e);
    case (e.kind)
        K_ADD:   encode = r_type_word(`F7_ADD, e.rs2, e.rs1, `F3_ADD, e.rd);
        K_SUB:   encode = r_type_word(`F7_SUB, e.rs2, e.rs1, `F3_ADD, e.rd);
        K_DIVU:  encode = r_type_word(`F7_MULDIV, e.rs2, e.rs1, `F3_DIVU, e.rd);
        K_ADDI:  encode = i_type_word(e.imm, e.rs1, `F3_ADD, e.rd, `OPC_OPIMM);
        K_LW:    encode = i_type_word(e.imm, e.rs1, `F3_WORD, e.rd, `OPC_LOAD);
        default: encode = s_type_word(e.imm, e.rs2, e.rs1);
    endcase
endfunction

// initial memory contents, scrambled from the byte address
function automatic word_t fill_word(input word_t addr);
    fill_word = (addr * 32'h9E37_79B1) ^ 32'h5A5A_0F0F;
endfunction

// galois form, x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

task automatic stop_run();
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped at the first error");
endtask

task automatic abort_run(input string why);
    $display("[ERROR] t=%0d ns: %s", $time, why);
    stop_run();
endtask

task automatic report_mismatch(input string name, input word_t exp, input word_t act);
    $display("[FAIL] t=%0d ns: %s expected 0x%08h, got 0x%08h", $time, name, exp, act);
    stop_run();
endtask

// one cycle on, looking once the falling-edge drive has settled
task automatic next_sample();
    @(negedge clk);
    #1;
endtask

task automatic add_instr(input kind_t k, input int rd, input int rs1, input int rs2,
                         input int imm);
    prog[n_instr].kind    = k;
    prog[n_instr].rd      = 5'(rd);
    prog[n_instr].rs1     = 5'(rs1);
    prog[n_instr].rs2     = 5'(rs2);
    prog[n_instr].imm     = 12'(imm);
    prog[n_instr].retires = 1'b0;   // filled in by the model
    prog[n_instr].value   = '0;
    n_instr++;
endtask

task automatic load_program();
    add_instr(K_ADDI,  1,  0,  0,    5);
    add_instr(K_ADDI,  2,  0,  0,    7);
    add_instr(K_ADD,   3,  1,  2,    0);   // x2 from MEM, x1 from WB
    add_instr(K_SUB,   4,  3,  1,    0);   // x1 through the register bypass
    add_instr(K_ADD,   5,  4,  3,    0);
    add_instr(K_ADDI,  6,  5,  0, -100);
    add_instr(K_SUB,   6,  6,  2,    0);   // reads and writes the same register
    add_instr(K_ADDI,  7,  0,  0,   11);
    add_instr(K_ADDI,  0,  7,  0,    9);   // x0 target, no retire
    add_instr(K_ADDI,  8,  0,  0,    1);
    add_instr(K_ADD,   9,  7,  0,    0);   // x7 written three back
    add_instr(K_ADD,   9,  9,  8,    0);
    add_instr(K_ADDI, 10,  0,  0,   64);   // data base
    add_instr(K_SW,    0, 10,  6,    0);   // base from MEM
    add_instr(K_LW,   11, 10,  0,    0);
    add_instr(K_ADD,  12, 11,  1,    0);   // load-use bubble
    add_instr(K_LW,   13, 10,  0,    4);   // never written, fill value
    add_instr(K_SW,    0, 10, 13,    8);   // store data right after load
    add_instr(K_LW,   14, 10,  0,    8);
    add_instr(K_SUB,  15, 14, 13,    0);   // expect zero
    add_instr(K_SW,    0, 10,  9,   -4);   // negative offset
    add_instr(K_LW,   16, 10,  0,   -4);
    add_instr(K_ADDI, 17,  0,  0, 1000);
    add_instr(K_ADDI, 18,  0,  0,    7);
    add_instr(K_DIVU, 19, 17, 18,    0);   // both operands forwarded
    add_instr(K_ADD,  20, 19,  1,    0);   // quotient from MEM
    add_instr(K_DIVU, 21, 17,  0,    0);   // divide by zero
    add_instr(K_ADDI, 22, 21,  0,    1);
    add_instr(K_DIVU, 23, 13, 18,    0);   // large dividend
    add_instr(K_DIVU, 24, 23,  2,    0);   // back to back divides
    add_instr(K_LW,   25, 10,  0,    0);
    add_instr(K_DIVU, 26, 25,  7,    0);   // load-use into the divider
    add_instr(K_ADDI, 27,  0,  0,   -1);
    add_instr(K_DIVU, 28, 27, 18,    0);
    add_instr(K_SW,    0, 10, 28,   12);
    add_instr(K_LW,   29, 10,  0,   12);
    add_instr(K_ADD,  30, 29, 26,    0);
    add_instr(K_ADD,  31, 30, 24,    0);
endtask

// RV32 semantics in program order, plus the cycle budget
task automatic build_expected();
    word_t  regs [0:31];
    word_t  mem  [0:63];
    word_t  a;
    word_t  b;
    word_t  addr;
    word_t  res;
    entry_t e;
    for (int i = 0; i < 32; i++) begin
        regs[i] = '0;
    end
    for (int i = 0; i < 64; i++) begin
        mem[i] = fill_word(word_t'(i) << 2);
    end
    for (int i = 0; i < n_instr; i++) begin
        e    = prog[i];
        a    = regs[e.rs1];
        b    = regs[e.rs2];
        addr = a + {{20{e.imm[11]}}, e.imm};
        res  = '0;
        limit += 8;
        if ((e.kind == K_LW) || (e.kind == K_SW)) begin
            limit += 4;
            if ((addr[31:8] != '0) || (addr[1:0] != 2'b00)) begin
                abort_run("program table uses an address outside the data window");
            end
        end
        case (e.kind)
            K_ADD:   res = a + b;
            K_SUB:   res = a - b;
            K_ADDI:  res = addr;              // same sum as an address
            K_LW:    res = mem[addr[7:2]];
            K_DIVU: begin
                res = (b == '0) ? '1 : a / b;
                limit += `DIV_CYCLES + 2;
            end
            default: mem[addr[7:2]] = b;      // store
        endcase
        e.retires = (e.kind != K_SW) && (e.rd != '0);
        e.value   = res;
        if (e.retires) begin
            regs[e.rd] = res;
            n_retire++;
        end
        prog[i] = e;
        rom[i]  = encode(e);
    end
endtask

task automatic check_retire();
    if (retire_valid) begin
        while ((next_ret < n_instr) && !prog[next_ret].retires) begin
            next_ret++;   // stores and x0 writes leave no strobe
        end
        assert (next_ret < n_instr)
            else abort_run("retire strobe after the whole program had retired");
        assert (retire_rd == prog[next_ret].rd)
            else report_mismatch("retire_rd", word_t'(prog[next_ret].rd), word_t'(retire_rd));
        assert (retire_value == prog[next_ret].value)
            else report_mismatch("retire_value", prog[next_ret].value, retire_value);
        next_ret++;
        n_seen++;
    end
endtask

// data memory, ready held low 0..3 cycles per request
always @(negedge clk) begin
    if (rst_n && dmem_req) begin
        if (!pending) begin
            wait_left[0] = lfsr[0];
            lfsr         = lfsr_next(lfsr);
            wait_left[1] = lfsr[0];
            lfsr         = lfsr_next(lfsr);
            pending      = 1'b1;
        end
        if (dmem_addr[31:8] != '0) begin
            abort_run("core accessed data memory outside the modeled window");
        end
        if (wait_left == 2'd0) begin
            dmem_ready = 1'b1;                  // completes at the next rising edge
            dmem_rdata = dmem[dmem_addr[7:2]];
            if (dmem_we) begin
                dmem[dmem_addr[7:2]] = dmem_wdata;
            end
            pending    = 1'b0;
        end else begin
            dmem_ready = 1'b0;
            wait_left  = wait_left - 2'd1;
        end
    end else begin
        dmem_ready = 1'b0;
    end
end

initial begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    dmem_ready = 1'b0;
    dmem_rdata = '0;
    lfsr       = 32'd83705;
    pending    = 1'b0;
    wait_left  = 2'd0;
    n_instr    = 0;
    n_retire   = 0;
    n_seen     = 0;
    next_ret   = 0;
    cycles     = 0;
    limit      = 20;
    for (int i = 0; i < MAX_INSTR; i++) begin
        rom[i] = NOP;
    end
    for (int i = 0; i < 64; i++) begin
        dmem[i] = fill_word(word_t'(i) << 2);
    end
    load_program();
    build_expected();
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    while (n_seen < n_retire) begin
        next_sample();
        check_retire();
        cycles++;
        if (cycles > limit) begin
            abort_run($sformatf("timeout, %0d of %0d retires seen after %0d cycles",
                                n_seen, n_retire, cycles));
        end
    end
    repeat (10) begin       // NOP tail must stay quiet
        next_sample();
        check_retire();
    end
    $display("TEST RESULT: PASS");
    $finish;
end

endmodule

`default_nettype wire

// File: src.f
+incdir+hdl
hdl/core_pkg.sv
hdl/hazard_unit.sv
hdl/reg_file.sv
hdl/instr_decoder.sv
hdl/iter_divider.sv
hdl/pipe_core.sv
test/pipe_core_assert.sv
test/pipe_core_tb.sv

// File: Makefile
TOP := pipe_core_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f src.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir
